// ==== pkt_settings.svh ====
`ifndef PKT_SETTINGS_SVH
`define PKT_SETTINGS_SVH

// address width of both byte RAMs
`define PKT_AW 8

// first byte of every packet on the serial line
`define PKT_SYNC 8'hA5

// packets sent in one run, one per kind
`define PKT_NUM 7

`endif

// ==== pkt_pkg.sv ====
`include "pkt_settings.svh"

package pkt_pkg;

    typedef enum logic [3:0] {
        ACK   = 4'd1,
        NAK   = 4'd2,
        STALL = 4'd3,
        DLINK = 4'd8,
        DTYPE = 4'd9,
        DTEMP = 4'd10,
        DATA0 = 4'd13
    } pkt_kind_t;

    typedef enum logic [1:0] {
        OK       = 2'd0,
        BAD_SUM  = 2'd1,
        BAD_KIND = 2'd2
    } pkt_stat_t;

    typedef struct packed {
        logic [3:0]          didx;
        logic [7:0]          link_val;
        logic [7:0]          type_val;
        logic [7:0]          temp_val;
        logic [`PKT_AW-1:0]  tx_base;
        logic [`PKT_AW-1:0]  rx_base;
        logic [7:0]          len;
        logic [`PKT_NUM-1:0] err_mask; // bit i spoils the checksum of packet i
    } run_cfg_t;

    typedef struct packed {
        pkt_kind_t          kind;
        logic [3:0]         didx;
        logic [7:0]         value;    // ignored for DATA0
        logic [`PKT_AW-1:0] tx_base;
        logic [7:0]         len;
        logic               corrupt;
    } pkt_cmd_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } com_t;

    typedef struct packed {
        logic [3:0] kind;  // raw field, may hold an unknown kind
        logic [3:0] didx;
        pkt_stat_t  stat;
        logic [7:0] value;
        logic [7:0] len;
        logic [2:0] seq;
    } pkt_result_t;

endpackage

// ==== dp_ram.sv ====
`timescale 1ns/10ps
`include "pkt_settings.svh"

module dp_ram (
    input  logic               clk,
    input  logic               we,
    input  logic [`PKT_AW-1:0] waddr,
    input  logic [7:0]         wdata,
    input  logic [`PKT_AW-1:0] raddr,
    output logic [7:0]         rdata
);

    logic [7:0] mem [0:(1 << `PKT_AW)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        rdata <= mem[raddr]; // data shows up one cycle after the address
    end

    assert property (@(posedge clk) we |-> !$isunknown(waddr))
        else $error("dp_ram write with unknown address");

endmodule

// ==== pkt_tx.sv ====
`timescale 1ns/10ps
`include "pkt_settings.svh"

module pkt_tx import pkt_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               fs,
    output logic               fd,
    input  pkt_cmd_t           cmd,
    output logic [`PKT_AW-1:0] ram_raddr,
    input  logic [7:0]         ram_rdata,
    output com_t               com_tx
);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_SYNC,
        TX_HEAD,
        TX_VAL,
        TX_PAY,
        TX_SUM,
        TX_DONE,
        TX_WAIT
    } tx_state_t;

    tx_state_t          state;
    pkt_cmd_t           cmd_q;
    logic [7:0]         sum;
    logic [7:0]         rem;
    logic [`PKT_AW-1:0] rd_idx;
    logic [7:0]         tx_byte;
    logic               is_data;
    logic               short_kind;

    assign is_data = (cmd_q.kind == DATA0);
    // anything without a value or length byte goes straight to the checksum
    assign short_kind = !is_data && (cmd_q.kind != DLINK) && (cmd_q.kind != DTYPE)
                        && (cmd_q.kind != DTEMP);

    assign ram_raddr = cmd_q.tx_base + rd_idx; // runs one byte ahead of the line

    always_comb begin
        case (state)
            TX_SYNC: tx_byte = `PKT_SYNC;
            TX_HEAD: tx_byte = {cmd_q.kind, cmd_q.didx};
            TX_VAL:  tx_byte = is_data ? cmd_q.len : cmd_q.value;
            TX_PAY:  tx_byte = ram_rdata;
            TX_SUM:  tx_byte = cmd_q.corrupt ? ~sum : sum;
            default: tx_byte = 8'h00;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= TX_IDLE;
            fd     <= 1'b0;
            com_tx <= '0;
            cmd_q  <= '0;
            sum    <= '0;
            rem    <= '0;
            rd_idx <= '0;
        end else begin
            fd           <= (state == TX_DONE); // the checksum byte is on the line in TX_DONE
            com_tx.valid <= 1'b0;
            com_tx.data  <= tx_byte;
            case (state)
                TX_IDLE: begin
                    if (fs) begin
                        cmd_q  <= cmd;
                        rd_idx <= '0;
                        sum    <= '0;
                        state  <= TX_SYNC; // this cycle covers the RAM prefetch
                    end
                end
                TX_SYNC: begin
                    com_tx.valid <= 1'b1;
                    state        <= TX_HEAD;
                end
                TX_HEAD: begin
                    com_tx.valid <= 1'b1;
                    sum          <= sum ^ tx_byte;
                    state        <= short_kind ? TX_SUM : TX_VAL;
                end
                TX_VAL: begin
                    com_tx.valid <= 1'b1;
                    sum          <= sum ^ tx_byte;
                    rem          <= cmd_q.len;
                    rd_idx       <= rd_idx + 1'b1;
                    state        <= (is_data && cmd_q.len != 8'd0) ? TX_PAY : TX_SUM;
                end
                TX_PAY: begin
                    com_tx.valid <= 1'b1;
                    sum          <= sum ^ tx_byte;
                    rem          <= rem - 1'b1;
                    rd_idx       <= rd_idx + 1'b1;
                    if (rem == 8'd1) begin
                        state <= TX_SUM;
                    end
                end
                TX_SUM: begin
                    com_tx.valid <= 1'b1;
                    state        <= TX_DONE;
                end
                TX_DONE: begin
                    state <= TX_WAIT;
                end
                default: begin
                    if (!fs) begin
                        state <= TX_IDLE; // fs must go low before the next packet
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) $rose(com_tx.valid) |-> fs)
        else $error("pkt_tx started a packet without fs");

endmodule

// ==== pkt_rx.sv ====
`timescale 1ns/10ps
`include "pkt_settings.svh"

module pkt_rx import pkt_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               fs,
    output logic               fd,
    input  logic [`PKT_AW-1:0] rx_base,
    input  com_t               com_rx,
    output logic               ram_we,
    output logic [`PKT_AW-1:0] ram_waddr,
    output logic [7:0]         ram_wdata,
    output pkt_result_t        result
);

    typedef enum logic [3:0] {
        RX_IDLE,
        RX_HUNT,
        RX_HEAD,
        RX_VAL,
        RX_LEN,
        RX_PAY,
        RX_SUM,
        RX_DONE,
        RX_WAIT
    } rx_state_t;

    rx_state_t          state;
    logic [3:0]         kind_q;
    logic [3:0]         didx_q;
    logic [7:0]         value_q;
    logic [7:0]         len_q;
    pkt_stat_t          stat_q;
    logic [7:0]         sum;
    logic [7:0]         rem;
    logic [`PKT_AW-1:0] wptr;
    logic               bad_kind;
    logic [3:0]         hdr_kind;

    assign hdr_kind = com_rx.data[7:4];
    assign fd = (state == RX_DONE);
    assign result = '{kind: kind_q, didx: didx_q, stat: stat_q, value: value_q,
                      len: len_q, seq: 3'd0};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= RX_IDLE;
            kind_q    <= '0;
            didx_q    <= '0;
            value_q   <= '0;
            len_q     <= '0;
            stat_q    <= OK;
            sum       <= '0;
            rem       <= '0;
            wptr      <= '0;
            bad_kind  <= 1'b0;
            ram_we    <= 1'b0;
            ram_waddr <= '0;
            ram_wdata <= '0;
        end else begin
            ram_we    <= (state == RX_PAY) && com_rx.valid;
            ram_waddr <= wptr;
            ram_wdata <= com_rx.data;
            case (state)
                RX_IDLE: begin
                    if (fs) begin
                        kind_q   <= '0;
                        didx_q   <= '0;
                        value_q  <= '0;
                        len_q    <= '0;
                        stat_q   <= OK;
                        bad_kind <= 1'b0;
                        wptr     <= rx_base;
                        state    <= RX_HUNT;
                    end
                end
                RX_HUNT: begin
                    if (com_rx.valid && com_rx.data == `PKT_SYNC) begin
                        state <= RX_HEAD;
                    end
                end
                RX_HEAD: begin
                    if (com_rx.valid) begin
                        kind_q <= hdr_kind;
                        didx_q <= com_rx.data[3:0];
                        sum    <= com_rx.data; // sync is not part of the checksum
                        case (hdr_kind)
                            ACK, NAK, STALL:     state <= RX_SUM;
                            DLINK, DTYPE, DTEMP: state <= RX_VAL;
                            DATA0:               state <= RX_LEN;
                            default: begin
                                bad_kind <= 1'b1;
                                state    <= RX_SUM;
                            end
                        endcase
                    end
                end
                RX_VAL: begin
                    if (com_rx.valid) begin
                        value_q <= com_rx.data;
                        sum     <= sum ^ com_rx.data;
                        state   <= RX_SUM;
                    end
                end
                RX_LEN: begin
                    if (com_rx.valid) begin
                        len_q <= com_rx.data;
                        rem   <= com_rx.data;
                        sum   <= sum ^ com_rx.data;
                        state <= (com_rx.data == 8'd0) ? RX_SUM : RX_PAY;
                    end
                end
                RX_PAY: begin
                    if (com_rx.valid) begin
                        sum  <= sum ^ com_rx.data;
                        rem  <= rem - 1'b1;
                        wptr <= wptr + 1'b1;
                        if (rem == 8'd1) begin
                            state <= RX_SUM;
                        end
                    end
                end
                RX_SUM: begin
                    if (com_rx.valid) begin
                        if (bad_kind) begin
                            stat_q <= BAD_KIND;
                        end else begin
                            stat_q <= (com_rx.data == sum) ? OK : BAD_SUM;
                        end
                        state <= RX_DONE;
                    end
                end
                RX_DONE: begin
                    state <= RX_WAIT;
                end
                default: begin
                    if (!fs) begin
                        state <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // the write lags its byte by one cycle so the last one lands in RX_SUM
    assert property (@(posedge clk) disable iff (rst)
                     ram_we |-> (kind_q == DATA0) && (state == RX_PAY || state == RX_SUM))
        else $error("pkt_rx wrote the RAM outside the payload");

endmodule

// ==== link_seq.sv ====
`timescale 1ns/10ps
`include "pkt_settings.svh"

module link_seq import pkt_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  run_cfg_t    cfg,
    output logic        busy,
    output logic        tx_fs,
    input  logic        tx_fd,
    output pkt_cmd_t    tx_cmd,
    output logic        rx_fs,
    input  logic        rx_fd,
    input  pkt_result_t rx_result,
    output pkt_result_t result,
    output logic        result_valid,
    output logic        run_done
);

    typedef enum logic [1:0] {
        SQ_IDLE,
        SQ_ARM,
        SQ_WAIT,
        SQ_RES
    } seq_state_t;

    seq_state_t state;
    run_cfg_t   cfg_q;
    logic [2:0] idx;
    logic       tx_got;
    logic       rx_got;

    always_comb begin
        tx_cmd         = '0;
        tx_cmd.didx    = cfg_q.didx;
        tx_cmd.tx_base = cfg_q.tx_base;
        tx_cmd.len     = cfg_q.len;
        tx_cmd.corrupt = cfg_q.err_mask[idx];
        case (idx)
            3'd0: tx_cmd.kind = ACK;
            3'd1: tx_cmd.kind = NAK;
            3'd2: tx_cmd.kind = STALL;
            3'd3: begin
                tx_cmd.kind  = DLINK;
                tx_cmd.value = cfg_q.link_val;
            end
            3'd4: begin
                tx_cmd.kind  = DTYPE;
                tx_cmd.value = cfg_q.type_val;
            end
            3'd5: begin
                tx_cmd.kind  = DTEMP;
                tx_cmd.value = cfg_q.temp_val;
            end
            default: tx_cmd.kind = DATA0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= SQ_IDLE;
            cfg_q        <= '0;
            idx          <= '0;
            busy         <= 1'b0;
            tx_fs        <= 1'b0;
            rx_fs        <= 1'b0;
            tx_got       <= 1'b0;
            rx_got       <= 1'b0;
            result       <= '0;
            result_valid <= 1'b0;
            run_done     <= 1'b0;
        end else begin
            run_done <= 1'b0;
            case (state)
                SQ_IDLE: begin
                    if (start) begin
                        cfg_q <= cfg;
                        idx   <= '0;
                        busy  <= 1'b1;
                        rx_fs <= 1'b1; // receiver is armed one cycle before the sender
                        state <= SQ_ARM;
                    end
                end
                SQ_ARM: begin
                    tx_fs  <= 1'b1;
                    tx_got <= 1'b0;
                    rx_got <= 1'b0;
                    state  <= SQ_WAIT;
                end
                SQ_WAIT: begin
                    if (tx_fd) begin
                        tx_fs  <= 1'b0;
                        tx_got <= 1'b1;
                    end
                    if (rx_fd) begin
                        rx_fs      <= 1'b0;
                        rx_got     <= 1'b1;
                        result     <= rx_result;
                        result.seq <= idx;
                    end
                    if ((tx_got || tx_fd) && (rx_got || rx_fd)) begin
                        result_valid <= 1'b1;
                        state        <= SQ_RES;
                    end
                end
                default: begin
                    result_valid <= 1'b0;
                    if (idx == 3'(`PKT_NUM - 1)) begin
                        run_done <= 1'b1;
                        busy     <= 1'b0;
                        state    <= SQ_IDLE;
                    end else begin
                        idx   <= idx + 1'b1;
                        rx_fs <= 1'b1;
                        state <= SQ_ARM;
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) (tx_fs || rx_fs) |-> busy)
        else $error("link_seq started a block while idle");

    // a slave only reports done while it is being driven
    assert property (@(posedge clk) disable iff (rst) tx_fd |-> tx_fs)
        else $error("tx done pulse without a matching start");

    assert property (@(posedge clk) disable iff (rst) rx_fd |-> rx_fs)
        else $error("rx done pulse without a matching start");

endmodule

// ==== pkt_link_top.sv ====
`timescale 1ns/10ps
`include "pkt_settings.svh"

module pkt_link_top import pkt_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  run_cfg_t           cfg,
    output logic               busy,
    output pkt_result_t        result,
    output logic               result_valid,
    output logic               run_done,
    input  logic               tx_we,
    input  logic [`PKT_AW-1:0] tx_waddr,
    input  logic [7:0]         tx_wdata,
    input  logic [`PKT_AW-1:0] rx_raddr,
    output logic [7:0]         rx_rdata,
    output com_t               com_tx,
    input  com_t               com_rx
);

    logic               tx_fs;
    logic               tx_fd;
    logic               rx_fs;
    logic               rx_fd;
    pkt_cmd_t           tx_cmd;
    pkt_result_t        rx_result;
    logic [`PKT_AW-1:0] tx_ram_raddr;
    logic [7:0]         tx_ram_rdata;
    logic               rx_ram_we;
    logic [`PKT_AW-1:0] rx_ram_waddr;
    logic [7:0]         rx_ram_wdata;

    link_seq u_seq (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .cfg          (cfg),
        .busy         (busy),
        .tx_fs        (tx_fs),
        .tx_fd        (tx_fd),
        .tx_cmd       (tx_cmd),
        .rx_fs        (rx_fs),
        .rx_fd        (rx_fd),
        .rx_result    (rx_result),
        .result       (result),
        .result_valid (result_valid),
        .run_done     (run_done)
    );

    pkt_tx u_tx (
        .clk       (clk),
        .rst       (rst),
        .fs        (tx_fs),
        .fd        (tx_fd),
        .cmd       (tx_cmd),
        .ram_raddr (tx_ram_raddr),
        .ram_rdata (tx_ram_rdata),
        .com_tx    (com_tx)
    );

    // the host keeps cfg steady for the whole run, the receiver takes rx_base at arm time
    pkt_rx u_rx (
        .clk       (clk),
        .rst       (rst),
        .fs        (rx_fs),
        .fd        (rx_fd),
        .rx_base   (cfg.rx_base),
        .com_rx    (com_rx),
        .ram_we    (rx_ram_we),
        .ram_waddr (rx_ram_waddr),
        .ram_wdata (rx_ram_wdata),
        .result    (rx_result)
    );

    dp_ram u_tx_ram (
        .clk   (clk),
        .we    (tx_we),
        .waddr (tx_waddr),
        .wdata (tx_wdata),
        .raddr (tx_ram_raddr),
        .rdata (tx_ram_rdata)
    );

    dp_ram u_rx_ram (
        .clk   (clk),
        .we    (rx_ram_we),
        .waddr (rx_ram_waddr),
        .wdata (rx_ram_wdata),
        .raddr (rx_raddr),
        .rdata (rx_rdata)
    );

endmodule

// ==== tb_pkt_link.sv ====
`timescale 1ns/10ps
`include "pkt_settings.svh"

module tb_pkt_link import pkt_pkg::*; ();

    logic               clk;
    logic               rst;
    logic               start;
    run_cfg_t           cfg;
    logic               busy;
    pkt_result_t        result;
    logic               result_valid;
    logic               run_done;
    logic               tx_we;
    logic [`PKT_AW-1:0] tx_waddr;
    logic [7:0]         tx_wdata;
    logic [`PKT_AW-1:0] rx_raddr;
    logic [7:0]         rx_rdata;
    com_t               com_tx;
    com_t               com_rx;

    logic [7:0]  ref_tx [0:(1 << `PKT_AW)-1]; // bytes written into the transmit RAM
    logic [31:0] lcg_state;
    logic        started;
    int          res_cnt;
    int          frame_idx;
    int          byte_pos;
    int          done_cnt;

    pkt_link_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .cfg          (cfg),
        .busy         (busy),
        .result       (result),
        .result_valid (result_valid),
        .run_done     (run_done),
        .tx_we        (tx_we),
        .tx_waddr     (tx_waddr),
        .tx_wdata     (tx_wdata),
        .rx_raddr     (rx_raddr),
        .rx_rdata     (rx_rdata),
        .com_tx       (com_tx),
        .com_rx       (com_rx)
    );

    assign com_rx = com_tx; // serial loopback

    always #2 clk = ~clk;

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
            else stop_fail($sformatf("ERR %s expected %0h actual %0h", name, exp, act));
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // packet order of every run
    function automatic logic [3:0] kind_at(input int i);
        case (i)
            0: return 4'h1;
            1: return 4'h2;
            2: return 4'h3;
            3: return 4'h8;
            4: return 4'h9;
            5: return 4'ha;
            default: return 4'hd;
        endcase
    endfunction

    function automatic logic [7:0] value_at(input int i, input run_cfg_t c);
        case (i)
            3: return c.link_val;
            4: return c.type_val;
            default: return c.temp_val;
        endcase
    endfunction

    function automatic int pkt_len(input int i, input logic [7:0] len);
        if (i < 3) begin
            return 3;
        end else if (i < 6) begin
            return 4;
        end
        return 4 + int'(len); // sync, header, length, payload and checksum
    endfunction

    always @(posedge clk) begin
        if (!rst) begin
            if (com_tx.valid) begin
                if (byte_pos == 0) begin
                    assert (frame_idx < `PKT_NUM) else stop_fail("more packets than kinds in a run");
                    check_val("com_tx.data sync", 32'(`PKT_SYNC), 32'(com_tx.data));
                end else if (byte_pos == 1) begin
                    check_val("com_tx.data header", 32'({kind_at(frame_idx), cfg.didx}),
                              32'(com_tx.data));
                end
                byte_pos++;
            end else if (byte_pos != 0) begin
                check_val("packet length", 32'(pkt_len(frame_idx, cfg.len)), 32'(byte_pos));
                frame_idx++;
                byte_pos = 0;
            end
            if (result_valid) begin
                assert (res_cnt < `PKT_NUM) else stop_fail("more results than packets in a run");
                check_val("result.seq", 32'(res_cnt), 32'(result.seq));
                check_val("result.kind", 32'(kind_at(res_cnt)), 32'(result.kind));
                check_val("result.didx", 32'(cfg.didx), 32'(result.didx));
                check_val("result.stat", cfg.err_mask[res_cnt] ? 32'(BAD_SUM) : 32'(OK),
                          32'(result.stat));
                if (res_cnt >= 3 && res_cnt <= 5) begin
                    check_val("result.value", 32'(value_at(res_cnt, cfg)), 32'(result.value));
                end
                if (res_cnt == 6) begin
                    check_val("result.len", 32'(cfg.len), 32'(result.len));
                end
                res_cnt++;
            end
            if (run_done) begin
                check_val("result count", 32'(`PKT_NUM), 32'(res_cnt));
                check_val("packet count", 32'(`PKT_NUM), 32'(frame_idx));
                res_cnt = 0;
                frame_idx = 0;
                done_cnt++;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
                     !started |-> !(com_tx.valid || result_valid || run_done || busy))
        else stop_fail("outputs became active before the first start");

    assert property (@(posedge clk) disable iff (rst) run_done |-> $past(result_valid))
        else stop_fail("run_done came without a final result the cycle before");

    assert property (@(posedge clk) disable iff (rst) result_valid |=> !result_valid)
        else stop_fail("result_valid stayed high for more than one cycle");

    task automatic wait_done(input int target);
        int n;
        n = 0;
        while (done_cnt < target && n < 5000) begin
            tick();
            n++;
        end
        if (done_cnt < target) begin
            stop_fail("timeout while waiting for run_done");
        end
    endtask

    task automatic check_payload();
        int                 i;
        logic [`PKT_AW-1:0] src;
        for (i = 0; i < int'(cfg.len); i++) begin
            src      = cfg.tx_base + `PKT_AW'(i);
            rx_raddr = cfg.rx_base + `PKT_AW'(i);
            tick(); // read data is registered
            check_val("rx_rdata", 32'(ref_tx[src]), 32'(rx_rdata));
        end
    endtask

    task automatic do_run(input int target, input logic [7:0] len, input logic [6:0] mask,
                          input logic poke);
        int                 i;
        logic [7:0]         d;
        logic [`PKT_AW-1:0] a;
        d            = rand_byte();
        cfg.didx     = d[3:0];
        cfg.link_val = rand_byte();
        cfg.type_val = rand_byte();
        cfg.temp_val = rand_byte();
        cfg.tx_base  = rand_byte();
        cfg.rx_base  = rand_byte();
        cfg.len      = len;
        cfg.err_mask = mask;
        for (i = 0; i < int'(len); i++) begin
            a         = cfg.tx_base + `PKT_AW'(i);
            d         = rand_byte();
            ref_tx[a] = d;
            tx_we     = 1'b1;
            tx_waddr  = a;
            tx_wdata  = d;
            tick();
        end
        tx_we   = 1'b0;
        started = 1'b1;
        start   = 1'b1;
        tick();
        start = 1'b0;
        if (poke) begin
            repeat (10) tick();
            check_val("busy", 32'd1, 32'(busy));
            start = 1'b1; // must be ignored while the run is going
            tick();
            start = 1'b0;
        end
        wait_done(target);
        repeat (20) tick();
        check_val("run_done count", 32'(target), 32'(done_cnt));
        check_val("busy", 32'd0, 32'(busy));
        check_payload();
    endtask

    initial begin
        logic [7:0] r8;
        clk       = 1'b0;
        rst       = 1'b1;
        start     = 1'b0;
        cfg       = '0;
        tx_we     = 1'b0;
        tx_waddr  = '0;
        tx_wdata  = '0;
        rx_raddr  = '0;
        lcg_state = 32'd63;
        started   = 1'b0;
        res_cnt   = 0;
        frame_idx = 0;
        byte_pos  = 0;
        done_cnt  = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (8) tick();
        r8 = rand_byte();
        do_run(1, {2'b00, r8[5:0]} + 8'd1, 7'd0, 1'b0);
        r8 = rand_byte();
        do_run(2, {2'b00, r8[5:0]} + 8'd1, {r8[6:2], 1'b0, 1'b1}, 1'b0);
        do_run(3, 8'd0, 7'd0, 1'b1);
        do_run(4, 8'd255, 7'd0, 1'b1);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
pkt_pkg.sv
dp_ram.sv
pkt_tx.sv
pkt_rx.sv
link_seq.sv
pkt_link_top.sv
tb_pkt_link.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_pkt_link -f all.f -o tb_pkt_link_sim &&
./obj_dir/tb_pkt_link_sim || exit 1
